//--- hdl/dcache_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and codes for the direct-mapped, write-through data cache
// Byte address is {ptag, offset}. Word accesses only, low two bits ignored
// Blocks are four words and there are sixteen sets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dcache_pkg;

   localparam int DATA_W      = 32;
   localparam int PTAG_W      = 8;
   localparam int OFFSET_W    = 8;
   localparam int ADDR_W      = PTAG_W + OFFSET_W;

   // Offset split: index in bits 7..4, word select in bits 3..2
   localparam int SETS        = 16;
   localparam int INDEX_W     = 4;
   localparam int INDEX_LSB   = 4;
   localparam int BLOCK_WORDS = 4;
   localparam int WORD_SEL_W  = 2;
   localparam int WORD_LSB    = 2;
   localparam int BLOCK_W     = DATA_W * BLOCK_WORDS;

   localparam int OP_W = 2;
   localparam logic [OP_W-1:0] OP_LOAD  = 2'd0;
   localparam logic [OP_W-1:0] OP_STORE = 2'd1;

   localparam int FIFO_ELS   = 8;
   localparam int FIFO_PTR_W = 3;

   localparam int MEM_OP_W = 2;
   localparam logic [MEM_OP_W-1:0] MEM_READ_BLOCK = 2'd0;
   localparam logic [MEM_OP_W-1:0] MEM_WRITE_WORD = 2'd1;
   localparam logic [MEM_OP_W-1:0] MEM_READ_UC    = 2'd2;

   localparam int MISS_OP_W = 2;
   localparam logic [MISS_OP_W-1:0] MISS_FILL    = 2'd0;
   localparam logic [MISS_OP_W-1:0] MISS_WRITE   = 2'd1;
   localparam logic [MISS_OP_W-1:0] MISS_UC_READ = 2'd2;

endpackage

`default_nettype wire

//--- hdl/replay_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight-entry request FIFO that keeps entries until they commit
// Roll returns the read pointer to the oldest uncommitted entry
// Tag and uncached flag arrive one cycle after the rest of an entry
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module replay_fifo
   import dcache_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                v_i,
   input  logic [OP_W-1:0]     op_i,
   input  logic [OFFSET_W-1:0] offset_i,
   input  logic [DATA_W-1:0]   data_i,
   input  logic [PTAG_W-1:0]   ptag_i,
   input  logic                uncached_i,
   input  logic                yumi_i,
   input  logic                commit_i,
   input  logic                roll_i,
   output logic                ready_o,
   output logic                head_v_o,
   output logic [OP_W-1:0]     head_op_o,
   output logic [OFFSET_W-1:0] head_offset_o,
   output logic [DATA_W-1:0]   head_data_o,
   output logic [PTAG_W-1:0]   head_ptag_o,
   output logic                head_uncached_o
);

   logic [OP_W-1:0]     op_mem     [FIFO_ELS];
   logic [OFFSET_W-1:0] offset_mem [FIFO_ELS];
   logic [DATA_W-1:0]   data_mem   [FIFO_ELS];
   logic [PTAG_W-1:0]   ptag_mem   [FIFO_ELS];
   logic                uc_mem     [FIFO_ELS];

   // Pointers carry a wrap bit
   logic [FIFO_PTR_W:0]   wptr_r, rptr_r, cptr_r, used;
   logic [FIFO_PTR_W-1:0] pend_idx_r, head_idx;
   logic                  pend_v_r, head_pend, enq;

   assign used     = wptr_r - cptr_r;
   // Full when all eight entries are uncommitted
   assign ready_o  = !used[FIFO_PTR_W];
   assign enq      = v_i && ready_o;
   assign head_v_o = rptr_r != wptr_r;
   assign head_idx = rptr_r[FIFO_PTR_W-1:0];

   // Newest entry's tag is still on the input pins
   assign head_pend       = pend_v_r && (pend_idx_r == head_idx);
   assign head_op_o       = op_mem[head_idx];
   assign head_offset_o   = offset_mem[head_idx];
   assign head_data_o     = data_mem[head_idx];
   assign head_ptag_o     = head_pend ? ptag_i : ptag_mem[head_idx];
   assign head_uncached_o = head_pend ? uncached_i : uc_mem[head_idx];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_r   <= '0;
         rptr_r   <= '0;
         cptr_r   <= '0;
         pend_v_r <= 1'b0;
      end
      else
      begin
         pend_v_r <= enq;
         wptr_r   <= wptr_r + enq;
         cptr_r   <= cptr_r + commit_i;
         if (roll_i)
            rptr_r <= cptr_r;
         else
            rptr_r <= rptr_r + yumi_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      pend_idx_r <= wptr_r[FIFO_PTR_W-1:0];
      if (enq)
      begin
         op_mem[wptr_r[FIFO_PTR_W-1:0]]     <= op_i;
         offset_mem[wptr_r[FIFO_PTR_W-1:0]] <= offset_i;
         data_mem[wptr_r[FIFO_PTR_W-1:0]]   <= data_i;
      end
      if (pend_v_r)
      begin
         ptag_mem[pend_idx_r] <= ptag_i;
         uc_mem[pend_idx_r]   <= uncached_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/dcache_pipe.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-stage load/store pipeline, decision two cycles after acceptance
// Every accepted request ends in either v_o or replay_o, never both
// Misses are not held, the replayed request raises them again
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache_pipe
   import dcache_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  head_v_i,
   input  logic [OP_W-1:0]       head_op_i,
   input  logic [OFFSET_W-1:0]   head_offset_i,
   input  logic [DATA_W-1:0]     head_data_i,
   input  logic [PTAG_W-1:0]     head_ptag_i,
   input  logic                  head_uncached_i,
   input  logic [PTAG_W-1:0]     rd_tag_i,
   input  logic                  rd_valid_i,
   input  logic [BLOCK_W-1:0]    rd_data_i,
   input  logic                  fill_busy_i,
   input  logic                  miss_yumi_i,
   input  logic                  miss_busy_i,
   input  logic                  uc_v_i,
   input  logic [DATA_W-1:0]     uc_data_i,
   output logic                  yumi_o,
   output logic [INDEX_W-1:0]    rd_index_o,
   output logic                  wr_v_o,
   output logic [INDEX_W-1:0]    wr_index_o,
   output logic [WORD_SEL_W-1:0] wr_sel_o,
   output logic [DATA_W-1:0]     wr_data_o,
   output logic                  miss_v_o,
   output logic [MISS_OP_W-1:0]  miss_kind_o,
   output logic [ADDR_W-1:0]     miss_addr_o,
   output logic [DATA_W-1:0]     miss_data_o,
   output logic                  v_o,
   output logic [DATA_W-1:0]     data_o,
   output logic                  replay_o
);

   logic                  s1_v_r, s2_v_r, s1_uc_r, s2_uc_r;
   logic [OP_W-1:0]       s1_op_r, s2_op_r;
   logic [OFFSET_W-1:0]   s1_offset_r, s2_offset_r;
   logic [DATA_W-1:0]     s1_data_r, s2_data_r;
   logic [PTAG_W-1:0]     s1_ptag_r, s2_ptag_r;
   logic                  uc_buf_v_r, s2_store, s2_hit, s2_done, uc_take;
   logic [DATA_W-1:0]     uc_buf_r, hit_word;
   logic [WORD_SEL_W-1:0] s2_sel;

   assign yumi_o     = head_v_i && !miss_busy_i && !fill_busy_i && !replay_o;
   assign rd_index_o = s1_offset_r[INDEX_LSB +: INDEX_W];

   assign s2_store = s2_op_r == OP_STORE;
   assign s2_sel   = s2_offset_r[WORD_LSB +: WORD_SEL_W];
   assign s2_hit   = rd_valid_i && (rd_tag_i == s2_ptag_r);
   assign hit_word = rd_data_i[s2_sel*DATA_W +: DATA_W];

   assign miss_addr_o = {s2_ptag_r, s2_offset_r};
   assign miss_data_o = s2_data_r;
   assign wr_v_o      = s2_v_r && s2_store && s2_hit && miss_yumi_i;
   assign wr_index_o  = s2_offset_r[INDEX_LSB +: INDEX_W];
   assign wr_sel_o    = s2_sel;
   assign wr_data_o   = s2_data_r;
   assign v_o         = s2_done;
   assign replay_o    = s2_v_r && !s2_done;

   always_comb
   begin
      miss_v_o    = 1'b0;
      miss_kind_o = MISS_FILL;
      s2_done     = 1'b0;
      uc_take     = 1'b0;
      data_o      = hit_word;
      if (s2_v_r)
      begin
         if (s2_store)
         begin
            // Write-through store completes once the engine owns it
            miss_v_o    = 1'b1;
            miss_kind_o = MISS_WRITE;
            s2_done     = miss_yumi_i;
            data_o      = '0;
         end
         else if (s2_uc_r)
         begin
            miss_v_o    = !uc_buf_v_r;
            miss_kind_o = MISS_UC_READ;
            s2_done     = uc_buf_v_r;
            uc_take     = uc_buf_v_r;
            data_o      = uc_buf_r;
         end
         else
         begin
            miss_v_o = !s2_hit;
            s2_done  = s2_hit;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         s1_v_r     <= 1'b0;
         s2_v_r     <= 1'b0;
         uc_buf_v_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= yumi_o;
         // Replay also drops the younger request in stage 1
         s2_v_r <= s1_v_r && !replay_o;
         if (uc_v_i)
            uc_buf_v_r <= 1'b1;
         else if (uc_take)
            uc_buf_v_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (yumi_o)
      begin
         s1_op_r     <= head_op_i;
         s1_offset_r <= head_offset_i;
         s1_data_r   <= head_data_i;
         s1_ptag_r   <= head_ptag_i;
         s1_uc_r     <= head_uncached_i;
      end
      s2_op_r     <= s1_op_r;
      s2_offset_r <= s1_offset_r;
      s2_data_r   <= s1_data_r;
      s2_ptag_r   <= s1_ptag_r;
      s2_uc_r     <= s1_uc_r;
      if (uc_v_i)
         uc_buf_r <= uc_data_i;
   end

endmodule

`default_nettype wire

//--- hdl/dcache_arrays.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped tag, valid and data storage, 16 blocks of 128 bits
// Read is registered; a same-cycle store word is forwarded into it
// Fill wins over a store write in the same cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache_arrays
   import dcache_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [INDEX_W-1:0]    rd_index_i,
   input  logic                  wr_v_i,
   input  logic [INDEX_W-1:0]    wr_index_i,
   input  logic [WORD_SEL_W-1:0] wr_sel_i,
   input  logic [DATA_W-1:0]     wr_data_i,
   input  logic                  fill_v_i,
   input  logic [INDEX_W-1:0]    fill_index_i,
   input  logic [PTAG_W-1:0]     fill_tag_i,
   input  logic [BLOCK_W-1:0]    fill_block_i,
   output logic [PTAG_W-1:0]     rd_tag_o,
   output logic                  rd_valid_o,
   output logic [BLOCK_W-1:0]    rd_data_o
);

   logic [PTAG_W-1:0]  tag_mem  [SETS];
   logic [BLOCK_W-1:0] data_mem [SETS];
   logic [SETS-1:0]    valid_r;
   logic [BLOCK_W-1:0] rd_block;

   always_comb
   begin
      rd_block = data_mem[rd_index_i];
      if (wr_v_i && !fill_v_i && (wr_index_i == rd_index_i))
         rd_block[wr_sel_i*DATA_W +: DATA_W] = wr_data_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
      begin
         tag_mem[fill_index_i]  <= fill_tag_i;
         data_mem[fill_index_i] <= fill_block_i;
      end
      else if (wr_v_i)
         data_mem[wr_index_i][wr_sel_i*DATA_W +: DATA_W] <= wr_data_i;
      rd_tag_o  <= tag_mem[rd_index_i];
      rd_data_o <= rd_block;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         valid_r    <= '0;
         rd_valid_o <= 1'b0;
      end
      else
      begin
         if (fill_v_i)
            valid_r[fill_index_i] <= 1'b1;
         rd_valid_o <= valid_r[rd_index_i];
      end
   end

endmodule

`default_nettype wire

//--- hdl/miss_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One request at a time; command goes out the cycle after it is taken
// Writes finish when the command is accepted, reads on the response
// Response data must be the whole block holding the address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module miss_engine
   import dcache_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 miss_v_i,
   input  logic [MISS_OP_W-1:0] miss_kind_i,
   input  logic [ADDR_W-1:0]    miss_addr_i,
   input  logic [DATA_W-1:0]    miss_data_i,
   input  logic                 mem_cmd_ready_i,
   input  logic                 mem_resp_v_i,
   input  logic [BLOCK_W-1:0]   mem_resp_data_i,
   output logic                 miss_yumi_o,
   output logic                 busy_o,
   output logic                 fill_busy_o,
   output logic                 fill_v_o,
   output logic [INDEX_W-1:0]   fill_index_o,
   output logic [PTAG_W-1:0]    fill_tag_o,
   output logic [BLOCK_W-1:0]   fill_block_o,
   output logic                 uc_v_o,
   output logic [DATA_W-1:0]    uc_data_o,
   output logic                 mem_cmd_v_o,
   output logic [MEM_OP_W-1:0]  mem_cmd_op_o,
   output logic [ADDR_W-1:0]    mem_cmd_addr_o,
   output logic [DATA_W-1:0]    mem_cmd_data_o,
   output logic                 mem_resp_yumi_o
);

   logic                  cmd_v_r, wait_r;
   logic [MISS_OP_W-1:0]  kind_r;
   logic [ADDR_W-1:0]     addr_r;
   logic [DATA_W-1:0]     data_r;
   logic                  idle, cmd_fire, resp_fire, done;
   logic [WORD_SEL_W-1:0] word_sel;

   assign idle      = !cmd_v_r && !wait_r;
   assign cmd_fire  = cmd_v_r && mem_cmd_ready_i;
   assign resp_fire = wait_r && mem_resp_v_i;
   assign done      = (cmd_fire && (kind_r == MISS_WRITE)) || resp_fire;

   // Busy drops in the finishing cycle so the pipeline restarts early
   assign miss_yumi_o = miss_v_i && idle;
   assign busy_o      = !idle && !done;

   assign fill_v_o     = resp_fire && (kind_r == MISS_FILL);
   assign fill_busy_o  = fill_v_o;
   assign fill_index_o = addr_r[INDEX_LSB +: INDEX_W];
   assign fill_tag_o   = addr_r[ADDR_W-1 -: PTAG_W];
   assign fill_block_o = mem_resp_data_i;

   assign word_sel  = addr_r[WORD_LSB +: WORD_SEL_W];
   assign uc_v_o    = resp_fire && (kind_r == MISS_UC_READ);
   assign uc_data_o = mem_resp_data_i[word_sel*DATA_W +: DATA_W];

   assign mem_cmd_v_o     = cmd_v_r;
   assign mem_cmd_addr_o  = addr_r;
   assign mem_cmd_data_o  = data_r;
   assign mem_resp_yumi_o = resp_fire;

   always_comb
   begin
      case (kind_r)
         MISS_WRITE:   mem_cmd_op_o = MEM_WRITE_WORD;
         MISS_UC_READ: mem_cmd_op_o = MEM_READ_UC;
         default:      mem_cmd_op_o = MEM_READ_BLOCK;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cmd_v_r <= 1'b0;
         wait_r  <= 1'b0;
      end
      else
      begin
         if (miss_yumi_o)
            cmd_v_r <= 1'b1;
         else if (cmd_fire)
            cmd_v_r <= 1'b0;
         if (cmd_fire && (kind_r != MISS_WRITE))
            wait_r <= 1'b1;
         else if (resp_fire)
            wait_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (miss_yumi_o)
      begin
         kind_r <= miss_kind_i;
         addr_r <= miss_addr_i;
         data_r <= miss_data_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data cache with replay FIFO and a single outstanding memory operation
// ptag_i and uncached_i must follow one cycle after the request is taken
// Results come back in request order, stores return zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache_top
   import dcache_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                v_i,
   output logic                ready_o,
   input  logic [OP_W-1:0]     op_i,
   input  logic [OFFSET_W-1:0] offset_i,
   input  logic [DATA_W-1:0]   data_i,
   input  logic [PTAG_W-1:0]   ptag_i,
   input  logic                uncached_i,
   output logic                v_o,
   output logic [DATA_W-1:0]   data_o,
   output logic                mem_cmd_v_o,
   output logic [MEM_OP_W-1:0] mem_cmd_op_o,
   output logic [ADDR_W-1:0]   mem_cmd_addr_o,
   output logic [DATA_W-1:0]   mem_cmd_data_o,
   input  logic                mem_cmd_ready_i,
   input  logic                mem_resp_v_i,
   input  logic [BLOCK_W-1:0]  mem_resp_data_i,
   output logic                mem_resp_yumi_o
);

   logic                 head_v, head_yumi, head_uncached, replay;
   logic [OP_W-1:0]      head_op;
   logic [OFFSET_W-1:0]  head_offset;
   logic [DATA_W-1:0]    head_data;
   logic [PTAG_W-1:0]    head_ptag;

   logic [INDEX_W-1:0]    rd_index, wr_index, fill_index;
   logic [PTAG_W-1:0]     rd_tag, fill_tag;
   logic                  rd_valid, wr_v, fill_v, fill_busy;
   logic [BLOCK_W-1:0]    rd_data, fill_block;
   logic [WORD_SEL_W-1:0] wr_sel;
   logic [DATA_W-1:0]     wr_data;

   logic                 miss_v, miss_yumi, miss_busy, uc_v;
   logic [MISS_OP_W-1:0] miss_kind;
   logic [ADDR_W-1:0]    miss_addr;
   logic [DATA_W-1:0]    miss_data, uc_data;

   // A result frees its FIFO entry
   replay_fifo fifo (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .v_i(v_i), .op_i(op_i), .offset_i(offset_i), .data_i(data_i),
      .ptag_i(ptag_i), .uncached_i(uncached_i),
      .yumi_i(head_yumi), .commit_i(v_o), .roll_i(replay),
      .ready_o(ready_o), .head_v_o(head_v), .head_op_o(head_op),
      .head_offset_o(head_offset), .head_data_o(head_data),
      .head_ptag_o(head_ptag), .head_uncached_o(head_uncached)
   );

   dcache_pipe pipe (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .head_v_i(head_v), .head_op_i(head_op), .head_offset_i(head_offset),
      .head_data_i(head_data), .head_ptag_i(head_ptag),
      .head_uncached_i(head_uncached),
      .rd_tag_i(rd_tag), .rd_valid_i(rd_valid), .rd_data_i(rd_data),
      .fill_busy_i(fill_busy), .miss_yumi_i(miss_yumi), .miss_busy_i(miss_busy),
      .uc_v_i(uc_v), .uc_data_i(uc_data),
      .yumi_o(head_yumi), .rd_index_o(rd_index),
      .wr_v_o(wr_v), .wr_index_o(wr_index), .wr_sel_o(wr_sel), .wr_data_o(wr_data),
      .miss_v_o(miss_v), .miss_kind_o(miss_kind), .miss_addr_o(miss_addr),
      .miss_data_o(miss_data),
      .v_o(v_o), .data_o(data_o), .replay_o(replay)
   );

   dcache_arrays arrays (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .rd_index_i(rd_index),
      .wr_v_i(wr_v), .wr_index_i(wr_index), .wr_sel_i(wr_sel), .wr_data_i(wr_data),
      .fill_v_i(fill_v), .fill_index_i(fill_index), .fill_tag_i(fill_tag),
      .fill_block_i(fill_block),
      .rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_data_o(rd_data)
   );

   miss_engine engine (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .miss_v_i(miss_v), .miss_kind_i(miss_kind), .miss_addr_i(miss_addr),
      .miss_data_i(miss_data),
      .mem_cmd_ready_i(mem_cmd_ready_i), .mem_resp_v_i(mem_resp_v_i),
      .mem_resp_data_i(mem_resp_data_i),
      .miss_yumi_o(miss_yumi), .busy_o(miss_busy), .fill_busy_o(fill_busy),
      .fill_v_o(fill_v), .fill_index_o(fill_index), .fill_tag_o(fill_tag),
      .fill_block_o(fill_block), .uc_v_o(uc_v), .uc_data_o(uc_data),
      .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_op_o(mem_cmd_op_o),
      .mem_cmd_addr_o(mem_cmd_addr_o), .mem_cmd_data_o(mem_cmd_data_o),
      .mem_resp_yumi_o(mem_resp_yumi_o)
   );

endmodule

`default_nettype wire

//--- verification/tb_mem_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioural memory for the data cache testbench, covers all 16K words
// Word n starts as n ^ 5a5a0000; write commands update the image
// Ready and response are driven on the falling edge after stall_i cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
   import dcache_pkg::*;
(
   input  logic                clk_i,
   input  logic [2:0]          stall_i,
   input  logic                cmd_v_i,
   input  logic [MEM_OP_W-1:0] cmd_op_i,
   input  logic [ADDR_W-1:0]   cmd_addr_i,
   input  logic [DATA_W-1:0]   cmd_data_i,
   output logic                cmd_ready_o,
   output logic                resp_v_o,
   output logic [BLOCK_W-1:0]  resp_data_o,
   input  logic                resp_yumi_i,
   output int                  read_block_cnt_o,
   output int                  write_cnt_o,
   output int                  read_uc_cnt_o,
   output logic [ADDR_W-1:0]   last_wr_addr_o,
   output logic [DATA_W-1:0]   last_wr_data_o
);

   localparam int WORDS = 1 << (ADDR_W - 2);

   logic [DATA_W-1:0] image [WORDS];
   logic              pend;
   logic [ADDR_W-1:0] pend_addr;
   int                cmd_wait, resp_wait;

   initial
   begin
      for (int n = 0; n < WORDS; n++)
         image[n] = n ^ 32'h5a5a0000;
      pend             = 1'b0;
      pend_addr        = '0;
      cmd_wait         = 0;
      resp_wait        = 0;
      cmd_ready_o      = 1'b0;
      resp_v_o         = 1'b0;
      resp_data_o      = '0;
      read_block_cnt_o = 0;
      write_cnt_o      = 0;
      read_uc_cnt_o    = 0;
      last_wr_addr_o   = '0;
      last_wr_data_o   = '0;
   end

   // Transfers complete on the rising edge
   always @(posedge clk_i)
   begin
      if (cmd_v_i && cmd_ready_o)
      begin
         if (cmd_op_i == MEM_WRITE_WORD)
         begin
            image[cmd_addr_i[ADDR_W-1:2]] = cmd_data_i;
            last_wr_addr_o = cmd_addr_i;
            last_wr_data_o = cmd_data_i;
            write_cnt_o++;
         end
         else
         begin
            pend      = 1'b1;
            pend_addr = cmd_addr_i;
            resp_wait = stall_i;
            if (cmd_op_i == MEM_READ_UC)
               read_uc_cnt_o++;
            else
               read_block_cnt_o++;
         end
      end
      if (resp_v_o && resp_yumi_i)
         pend = 1'b0;
   end

   always @(negedge clk_i)
   begin
      if (!cmd_v_i)
      begin
         cmd_ready_o = 1'b0;
         cmd_wait    = stall_i;
      end
      else if (cmd_wait == 0)
         cmd_ready_o = 1'b1;
      else
         cmd_wait--;
      if (!pend)
         resp_v_o = 1'b0;
      else if (resp_wait == 0)
      begin
         // Whole block holding the address
         resp_v_o = 1'b1;
         for (int k = 0; k < BLOCK_WORDS; k++)
            resp_data_o[k*DATA_W +: DATA_W] = image[{pend_addr[ADDR_W-1:4], k[1:0]}];
      end
      else
         resp_wait--;
   end

endmodule

`default_nettype wire

//--- verification/tb_dcache_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests and a random stream for the data cache
// Expected results come from a shadow image updated in request order
// Stops at the first error; watchdog allows 400 cycles per request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_top
   import dcache_pkg::*;
();

   localparam int WORDS         = 1 << (ADDR_W - 2);
   localparam int DIRECTED_REQS = 10;
   localparam int RANDOM_REQS   = 200;

   logic                clk, rst_n;
   logic                req_v, req_ready, req_uncached, res_v;
   logic [OP_W-1:0]     req_op;
   logic [OFFSET_W-1:0] req_offset;
   logic [DATA_W-1:0]   req_data, res_data, exp_data;
   logic [PTAG_W-1:0]   req_ptag;
   logic                mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_yumi;
   logic [MEM_OP_W-1:0] mem_cmd_op;
   logic [ADDR_W-1:0]   mem_cmd_addr, last_wr_addr;
   logic [DATA_W-1:0]   mem_cmd_data, last_wr_data;
   logic [BLOCK_W-1:0]  mem_resp_data;
   int                  rb_cnt, wr_cnt, uc_cnt, rb_base, wr_base, uc_base;
   int                  accepted, committed;
   logic [DATA_W-1:0]   shadow [WORDS];
   logic [DATA_W-1:0]   exp_q [$];
   logic [2:0]          stall_tab [256];
   logic [7:0]          stall_idx;
   logic [2:0]          stall;
   logic [31:0]         lfsr_state;
   string               test_name;

   dcache_top UUT (
      .clk_i(clk), .rst_n_i(rst_n),
      .v_i(req_v), .ready_o(req_ready), .op_i(req_op), .offset_i(req_offset),
      .data_i(req_data), .ptag_i(req_ptag), .uncached_i(req_uncached),
      .v_o(res_v), .data_o(res_data),
      .mem_cmd_v_o(mem_cmd_v), .mem_cmd_op_o(mem_cmd_op), .mem_cmd_addr_o(mem_cmd_addr),
      .mem_cmd_data_o(mem_cmd_data), .mem_cmd_ready_i(mem_cmd_ready),
      .mem_resp_v_i(mem_resp_v), .mem_resp_data_i(mem_resp_data),
      .mem_resp_yumi_o(mem_resp_yumi)
   );

   tb_mem_model mem (
      .clk_i(clk), .stall_i(stall),
      .cmd_v_i(mem_cmd_v), .cmd_op_i(mem_cmd_op), .cmd_addr_i(mem_cmd_addr),
      .cmd_data_i(mem_cmd_data), .cmd_ready_o(mem_cmd_ready),
      .resp_v_o(mem_resp_v), .resp_data_o(mem_resp_data), .resp_yumi_i(mem_resp_yumi),
      .read_block_cnt_o(rb_cnt), .write_cnt_o(wr_cnt), .read_uc_cnt_o(uc_cnt),
      .last_wr_addr_o(last_wr_addr), .last_wr_data_o(last_wr_data)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   // Stall counts come from a table filled before reset
   assign stall = stall_tab[stall_idx];

   always @(posedge clk)
      stall_idx <= stall_idx + 8'd1;

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      report_error($sformatf("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act));
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function logic [31:0] lfsr_bits(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         bits       = {bits[30:0], fb};
      end
      return bits;
   endfunction

   // Results leave in request order
   always @(posedge clk)
   begin
      if (req_v && req_ready)
         accepted++;
      if (res_v)
      begin
         assert (exp_q.size() != 0)
         else
            report_error("A result arrived with no request outstanding");
         exp_data = exp_q.pop_front();
         assert (res_data == exp_data)
         else
            report_mismatch("result data", exp_data, res_data);
         committed++;
      end
   end

   always @(negedge clk)
   begin
      assert (accepted - committed <= FIFO_ELS)
      else
         report_error("More than eight requests are uncommitted");
      assert (req_ready || (accepted - committed == FIFO_ELS))
      else
         report_error("ready_o is low with fewer than eight requests uncommitted");
   end

   task automatic send(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input logic uc);
      logic [ADDR_W-3:0] w;
      w          = addr[ADDR_W-1:2];
      req_v      = 1'b1;
      req_op     = op;
      req_offset = addr[OFFSET_W-1:0];
      req_data   = data;
      while (!req_ready)
         @(negedge clk);
      if (op == OP_STORE)
      begin
         shadow[w] = data;
         exp_q.push_back('0);
      end
      else
         exp_q.push_back(shadow[w]);
      // Tag and uncached flag in the cycle after acceptance
      @(negedge clk);
      req_v        = 1'b0;
      req_ptag     = addr[ADDR_W-1 -: PTAG_W];
      req_uncached = uc;
   endtask

   task automatic drain();
      while (exp_q.size() != 0 || mem_cmd_v)
         @(negedge clk);
   endtask

   task automatic access(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data, input logic uc);
      send(op, addr, data, uc);
      drain();
   endtask

   task automatic check_cmds(input int rb, input int wr, input int uc);
      assert (rb_cnt - rb_base == rb)
      else
         report_mismatch("MEM_READ_BLOCK count", rb, rb_cnt - rb_base);
      assert (wr_cnt - wr_base == wr)
      else
         report_mismatch("MEM_WRITE_WORD count", wr, wr_cnt - wr_base);
      assert (uc_cnt - uc_base == uc)
      else
         report_mismatch("MEM_READ_UC count", uc, uc_cnt - uc_base);
      rb_base = rb_cnt;
      wr_base = wr_cnt;
      uc_base = uc_cnt;
   endtask

   task automatic check_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      assert (last_wr_addr == addr)
      else
         report_mismatch("write address", addr, last_wr_addr);
      assert (last_wr_data == data)
      else
         report_mismatch("write data", data, last_wr_data);
   endtask

   task automatic cold_load();
      test_name = "cold_load";
      access(OP_LOAD, 16'h1234, '0, 1'b0);
      check_cmds(1, 0, 0);
   endtask

   task automatic hit_load();
      test_name = "hit_load";
      access(OP_LOAD, 16'h1238, '0, 1'b0);
      check_cmds(0, 0, 0);
   endtask

   task automatic store_then_load();
      test_name = "store_then_load";
      // Line 3 is filled by now, line 7 is not
      access(OP_STORE, 16'h1230, 32'hcafe0001, 1'b0);
      check_cmds(0, 1, 0);
      check_write(16'h1230, 32'hcafe0001);
      access(OP_LOAD, 16'h1230, '0, 1'b0);
      check_cmds(0, 0, 0);
      access(OP_STORE, 16'h4570, 32'hbeef0002, 1'b0);
      check_cmds(0, 1, 0);
      check_write(16'h4570, 32'hbeef0002);
      access(OP_LOAD, 16'h4570, '0, 1'b0);
      check_cmds(1, 0, 0);
   endtask

   task automatic uncached_access();
      test_name = "uncached_access";
      access(OP_LOAD, 16'h6680, '0, 1'b1);
      check_cmds(0, 0, 1);
      access(OP_LOAD, 16'h6680, '0, 1'b0);
      check_cmds(1, 0, 0);
      access(OP_STORE, 16'h7790, 32'h0ddba115, 1'b1);
      check_cmds(0, 1, 0);
      check_write(16'h7790, 32'h0ddba115);
      access(OP_LOAD, 16'h7790, '0, 1'b1);
      check_cmds(0, 0, 1);
   endtask

   task automatic random_stream();
      logic [31:0] op_bit, uc_bits, tag_bits, off_bits, data;
      test_name = "random_stream";
      for (int i = 0; i < RANDOM_REQS; i++)
      begin
         op_bit   = lfsr_bits(1);
         uc_bits  = lfsr_bits(2);
         tag_bits = lfsr_bits(2);
         off_bits = lfsr_bits(6);
         data     = lfsr_bits(32);
         send(op_bit[0] ? OP_STORE : OP_LOAD, {6'd0, tag_bits[1:0], off_bits[5:0], 2'b00},
              data, uc_bits[1:0] == 2'd0);
      end
      drain();
      for (int w = 0; w < WORDS; w++)
      begin
         assert (mem.image[w] == shadow[w])
         else
            report_mismatch("memory image word", shadow[w], mem.image[w]);
      end
   endtask

   initial
   begin
      repeat (16 + 400 * (DIRECTED_REQS + RANDOM_REQS))
         @(posedge clk);
      report_error("Watchdog expired before the tests finished");
   end

   initial
   begin
      logic [31:0] r;
      rst_n        = 1'b0;
      req_v        = 1'b0;
      req_op       = OP_LOAD;
      req_offset   = '0;
      req_data     = '0;
      req_ptag     = '0;
      req_uncached = 1'b0;
      stall_idx    = '0;
      accepted     = 0;
      committed    = 0;
      rb_base      = 0;
      wr_base      = 0;
      uc_base      = 0;
      test_name    = "reset";
      lfsr_state   = 32'h7bf45aa4;
      for (int w = 0; w < WORDS; w++)
         shadow[w] = w ^ 32'h5a5a0000;
      for (int s = 0; s < 256; s++)
      begin
         r            = lfsr_bits(3);
         stall_tab[s] = r[2:0];
      end
      repeat (16)
         @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      cold_load();
      hit_load();
      store_then_load();
      uncached_access();
      random_stream();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
hdl/dcache_pkg.sv
hdl/replay_fifo.sv
hdl/dcache_pipe.sv
hdl/dcache_arrays.sv
hdl/miss_engine.sv
hdl/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
# The run fails if the log holds the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache_top \
   -f project.f -o tb_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim 2>&1 | tee sim.log
[ -s sim.log ] || { echo "Simulation produced no log"; exit 1; }
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
